// ==== project.f ====
+incdir+test
rtl/packet_pkg.sv
rtl/packet_sram.sv
rtl/packet_fifo.sv
rtl/packet_ctrl.sv
rtl/packet_store_top.sv
test/packet_store_tb.sv

// ==== rtl/packet_ctrl.sv ====
// Packet controller FSM (IDLE, STREAM, STALL)
// Arbitrates datapath write, edge write-back and replay read
// Owns SRAM write and read pointers

`timescale 1ns/100ps
`default_nettype none

module packet_ctrl (
    input  logic                               clk,
    input  logic                               reset,
    input  packet_pkg::packet_t                dp_packet,
    input  packet_pkg::edge_packets_t          edge_packets,
    input  logic                               full,
    input  logic                               cntl_done,
    input  logic                               replay_iter_flag,
    input  logic [packet_pkg::PACKET_BITS-1:0] rd_data,
    output packet_pkg::sram_req_t              sram_req,
    output packet_pkg::packet_t                fifo_push
);

    import packet_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        STREAM = 2'd1,
        STALL  = 2'd2
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t nx_state;

    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] rd_ptr;
    logic [ADDR_BITS-1:0] nx_wr_ptr;
    logic [ADDR_BITS-1:0] nx_rd_ptr;

    // Edge arbitration results
    logic                   edge_any;
    logic [PACKET_BITS-1:0] edge_word;

    // Chosen action for this cycle
    logic                   pending;
    logic                   do_write;
    logic                   do_read;
    logic [PACKET_BITS-1:0] write_word;

    // Highest valid index wins, so later iterations overwrite
    always_comb begin
        edge_any  = 1'b0;
        edge_word = '0;
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            if (edge_packets[i].valid) begin
                edge_any  = 1'b1;
                edge_word = edge_packets[i].packet;
            end
        end
    end

    // Stored lines not yet replayed
    assign pending = (rd_ptr != wr_ptr);

    // Datapath first, then edge write-back, then replay read
    always_comb begin
        do_write   = 1'b0;
        do_read    = 1'b0;
        write_word = dp_packet.packet;
        if (state == STREAM && !replay_iter_flag) begin
            if (dp_packet.valid) begin
                do_write = 1'b1;
            end else if (edge_any) begin
                do_write   = 1'b1;
                write_word = edge_word;
            end else if (pending && !full) begin
                do_read = 1'b1;
            end
        end
    end

    // Next state and pointers
    always_comb begin
        nx_state  = state;
        nx_wr_ptr = wr_ptr;
        nx_rd_ptr = rd_ptr;
        if (replay_iter_flag) begin
            // New iteration starts from line zero
            nx_state  = IDLE;
            nx_wr_ptr = '0;
            nx_rd_ptr = '0;
        end else begin
            if (do_write) begin
                nx_wr_ptr = wr_ptr + 1'b1;
            end
            if (do_read) begin
                nx_rd_ptr = rd_ptr + 1'b1;
            end
            case (state)
                IDLE: begin
                    nx_state = STREAM;
                end
                STREAM: begin
                    if (cntl_done) begin
                        nx_state = STALL;
                    end
                end
                STALL: begin
                    nx_state = STALL;
                end
                default: begin
                    nx_state = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            state  <= nx_state;
            wr_ptr <= nx_wr_ptr;
            rd_ptr <= nx_rd_ptr;
        end
    end

    // Address follows rd_ptr unless writing
    always_comb begin
        sram_req.wen_n = !do_write;
        sram_req.addr  = do_write ? wr_ptr : rd_ptr;
        sram_req.wdata = write_word;
    end

    // Read data goes straight into the queue
    always_comb begin
        fifo_push.valid  = do_read;
        fifo_push.packet = rd_data;
    end

endmodule

`default_nettype wire

// ==== rtl/packet_fifo.sv ====
// Output packet queue, first-word fall-through
// Circular buffer with head, tail and count, raises full

`timescale 1ns/100ps
`default_nettype none

module packet_fifo (
    input  logic                clk,
    input  logic                reset,
    input  packet_pkg::packet_t fifo_push,
    input  logic                pop,
    output packet_pkg::packet_t fifo_out,
    output logic                full
);

    import packet_pkg::*;

    logic [PACKET_BITS-1:0]     entries [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0]   head;
    logic [FIFO_PTR_BITS-1:0]   tail;
    logic [FIFO_COUNT_BITS-1:0] count;

    logic empty;
    logic do_push;
    logic do_pop;

    assign empty = (count == '0);
    assign full  = (count == FIFO_COUNT_BITS'(FIFO_DEPTH));

    // Pop on empty is ignored
    assign do_push = fifo_push.valid && !full;
    assign do_pop  = pop && !empty;

    // Payload storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[tail] <= fifo_push.packet;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= (tail == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (do_pop) begin
                head <= (head == FIFO_PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head shown whenever something is queued
    always_comb begin
        fifo_out.valid  = !empty;
        fifo_out.packet = entries[head];
    end

endmodule

`default_nettype wire

// ==== rtl/packet_pkg.sv ====
// Shared widths and depths for the packet store
// Packet word with valid, edge write-back bundle
// SRAM request carrying write enable, address and data

`default_nettype none

package packet_pkg;

    // Packet payload width
    localparam int PACKET_BITS = 32;

    // Packet SRAM geometry
    localparam int MAX_PACKET_LINES = 64;
    localparam int ADDR_BITS = $clog2(MAX_PACKET_LINES);

    // Number of edge processing elements writing back
    localparam int NUM_EDGE_PE = 4;

    // Output queue geometry
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_BITS = $clog2(FIFO_DEPTH + 1);

    // One packet with its valid flag
    typedef struct packed {
        logic                   valid;
        logic [PACKET_BITS-1:0] packet;
    } packet_t;

    // One slot per edge processing element, index 0 lowest priority
    typedef packet_t [NUM_EDGE_PE-1:0] edge_packets_t;

    // Single request per cycle to the packet SRAM
    typedef struct packed {
        logic                   wen_n;
        logic [ADDR_BITS-1:0]   addr;
        logic [PACKET_BITS-1:0] wdata;
    } sram_req_t;

endpackage

`default_nettype wire

// ==== rtl/packet_sram.sv ====
// Packet line memory
// Synchronous write on active-low enable, combinational read

`timescale 1ns/100ps
`default_nettype none

module packet_sram (
    input  logic                               clk,
    input  packet_pkg::sram_req_t              sram_req,
    output logic [packet_pkg::PACKET_BITS-1:0] rd_data
);

    import packet_pkg::*;

    logic [PACKET_BITS-1:0] lines [MAX_PACKET_LINES];

    // Write captured at the clock edge
    always_ff @(posedge clk) begin
        if (!sram_req.wen_n) begin
            lines[sram_req.addr] <= sram_req.wdata;
        end
    end

    // Line at the request address, read without a clock
    assign rd_data = lines[sram_req.addr];

endmodule

`default_nettype wire

// ==== rtl/packet_store_top.sv ====
// Packet store top level
// Controller, packet SRAM and output FIFO

`timescale 1ns/100ps
`default_nettype none

module packet_store_top (
    input  logic                      clk,
    input  logic                      reset,
    input  packet_pkg::packet_t       dp_packet,
    input  packet_pkg::edge_packets_t edge_packets,
    input  logic                      cntl_done,
    input  logic                      replay_iter_flag,
    input  logic                      pop,
    output packet_pkg::packet_t       fifo_out
);

    import packet_pkg::*;

    // Controller to SRAM
    sram_req_t              sram_req;
    logic [PACKET_BITS-1:0] rd_data;

    // Controller to FIFO
    packet_t fifo_push;
    logic    full;

    packet_ctrl u_ctrl (
        .clk              (clk),
        .reset            (reset),
        .dp_packet        (dp_packet),
        .edge_packets     (edge_packets),
        .full             (full),
        .cntl_done        (cntl_done),
        .replay_iter_flag (replay_iter_flag),
        .rd_data          (rd_data),
        .sram_req         (sram_req),
        .fifo_push        (fifo_push)
    );

    packet_sram u_sram (
        .clk      (clk),
        .sram_req (sram_req),
        .rd_data  (rd_data)
    );

    packet_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .fifo_push (fifo_push),
        .pop       (pop),
        .fifo_out  (fifo_out),
        .full      (full)
    );

endmodule

`default_nettype wire

// ==== test/packet_store_vectors.svh ====
// Stimulus table for the packet store testbench
// Each row is applied for count cycles

`ifndef PACKET_STORE_VECTORS_SVH
`define PACKET_STORE_VECTORS_SVH

// Columns are test, count, dp, edge mask, pop, done, replay and seed
// A zero seed takes packet words from the LFSR
task build_table;
    // Quiet after reset, then datapath packets in order
    add_step(1, 2, 0, 4'h0, 0, 0, 0, 32'h0);
    add_step(1, 3, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(1, 3, 0, 4'h0, 0, 0, 0, 32'h0);
    add_step(1, 3, 0, 4'h0, 1, 0, 0, 32'h0);
    add_step(1, 1, 0, 4'h0, 0, 0, 0, 32'h0);

    // Datapath beats edge and the highest edge index wins
    add_step(2, 1, 1, 4'hf, 0, 0, 0, 32'h1111_0000);
    add_step(2, 1, 0, 4'h5, 0, 0, 0, 32'h2222_0000);
    add_step(2, 1, 0, 4'hf, 0, 0, 0, 32'h0);
    add_step(2, 1, 0, 4'h3, 0, 0, 0, 32'h0);
    add_step(2, 4, 0, 4'h0, 0, 0, 0, 32'h0);
    add_step(2, 4, 0, 4'h0, 1, 0, 0, 32'h0);
    add_step(2, 1, 0, 4'h0, 0, 0, 0, 32'h0);

    // Writes go on while the FIFO is full and pops drain everything
    add_step(3, 6, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(3, 6, 0, 4'h0, 0, 0, 0, 32'h0);
    add_step(3, 2, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(3, 10, 0, 4'h0, 1, 0, 0, 32'h0);
    add_step(3, 2, 0, 4'h0, 0, 0, 0, 32'h0);

    // Done freezes the controller
    add_step(4, 2, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(4, 2, 0, 4'h0, 0, 0, 0, 32'h0);
    add_step(4, 1, 1, 4'h0, 0, 1, 0, 32'h0);
    add_step(4, 2, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(4, 3, 0, 4'h0, 0, 0, 0, 32'h0);
    add_step(4, 4, 0, 4'h0, 1, 0, 0, 32'h0);

    // Replay abandons unread lines
    // Datapath packets offered in the IDLE cycle are dropped
    add_step(5, 1, 0, 4'h0, 0, 0, 1, 32'h0);
    add_step(5, 1, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(5, 6, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(5, 6, 0, 4'h0, 0, 0, 0, 32'h0);
    add_step(5, 1, 0, 4'h0, 0, 0, 1, 32'h0);
    add_step(5, 1, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(5, 2, 1, 4'h0, 0, 0, 0, 32'h0);
    add_step(5, 2, 0, 4'h0, 0, 0, 0, 32'h0);
    add_step(5, 8, 0, 4'h0, 1, 0, 0, 32'h0);
    add_step(5, 2, 0, 4'h0, 0, 0, 0, 32'h0);
endtask

`endif

// ==== test/packet_store_tb.sv ====
// Testbench for the packet store
// Table-driven stimulus, queue reference model, checks and watchdog

`timescale 1ns/100ps
`default_nettype none

module packet_store_tb;

    import packet_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam logic [31:0] LFSR_SEED = 32'hf4c51bd2;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    // Reference controller states
    localparam int M_IDLE = 0;
    localparam int M_STREAM = 1;
    localparam int M_STALL = 2;

    // One expanded table row
    typedef struct packed {
        logic [7:0]  test;
        logic        dp;
        logic [3:0]  mask;
        logic        pop;
        logic        done;
        logic        replay;
        logic [31:0] seed;
    } step_t;

    logic          clk;
    logic          reset;
    packet_t       dp_packet;
    edge_packets_t edge_packets;
    logic          cntl_done;
    logic          replay_iter_flag;
    logic          pop;
    packet_t       fifo_out;

    step_t       steps[$];
    logic [31:0] lfsr_state;
    logic        table_ready;
    logic        checking;

    // Reference model of stored lines and queued packets
    int          m_state;
    logic [31:0] m_sram[$];
    logic [31:0] m_fifo[$];

    int cur_test;
    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int tests_passed;
    int tests_failed;

    packet_store_top dut (
        .clk              (clk),
        .reset            (reset),
        .dp_packet        (dp_packet),
        .edge_packets     (edge_packets),
        .cntl_done        (cntl_done),
        .replay_iter_flag (replay_iter_flag),
        .pop              (pop),
        .fifo_out         (fifo_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One output bit per LFSR step
    function logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {word[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return word;
    endfunction

    task add_step(input int test, input int count, input bit dp, input bit [3:0] mask,
                  input bit pop_req, input bit done, input bit replay,
                  input logic [31:0] seed);
        step_t s;
        s.test   = 8'(test);
        s.dp     = dp;
        s.mask   = mask;
        s.pop    = pop_req;
        s.done   = done;
        s.replay = replay;
        s.seed   = seed;
        repeat (count) steps.push_back(s);
    endtask

    `include "packet_store_vectors.svh"

    task check_value(input string name, input logic [31:0] got,
                     input logic [31:0] expected);
        test_checks++;
        total_checks++;
        if (got !== expected) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
            test_errors++;
            total_errors++;
        end
    endtask

    // Advance the model by one clock edge using the inputs the DUT samples
    task model_step;
        logic [31:0] read_word;
        bit          do_read;
        bit          written;
        read_word = '0;
        do_read   = 1'b0;
        written   = 1'b0;
        if (reset) begin
            m_state = M_IDLE;
            m_sram.delete();
            m_fifo.delete();
        end else begin
            if (replay_iter_flag) begin
                // Pointers back to zero, unread lines are lost
                m_sram.delete();
                m_state = M_IDLE;
            end else if (m_state == M_IDLE) begin
                m_state = M_STREAM;
            end else if (m_state == M_STREAM) begin
                if (dp_packet.valid) begin
                    m_sram.push_back(dp_packet.packet);
                    written = 1'b1;
                end
                // Highest-indexed edge element wins
                for (int i = NUM_EDGE_PE - 1; i >= 0; i--) begin
                    if (!written && edge_packets[i].valid) begin
                        m_sram.push_back(edge_packets[i].packet);
                        written = 1'b1;
                    end
                end
                if (!written && m_sram.size() != 0 && m_fifo.size() < FIFO_DEPTH) begin
                    do_read   = 1'b1;
                    read_word = m_sram.pop_front();
                end
                if (cntl_done) begin
                    m_state = M_STALL;
                end
            end
            // Output queue
            if (pop && m_fifo.size() != 0) begin
                m_fifo.delete(0);
            end
            if (do_read) begin
                m_fifo.push_back(read_word);
            end
        end
    endtask

    task apply_step(input step_t s);
        packet_t       dp_next;
        edge_packets_t edge_next;
        dp_next   = '0;
        edge_next = '0;
        if (s.dp) begin
            dp_next.valid = 1'b1;
            if (s.seed != 0) begin
                dp_next.packet = s.seed;
            end else begin
                dp_next.packet = random_word();
            end
        end
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            if (s.mask[i]) begin
                edge_next[i].valid = 1'b1;
                // Seeded words differ per element
                if (s.seed != 0) begin
                    edge_next[i].packet = s.seed ^ {8'(i + 1), 24'h0};
                end else begin
                    edge_next[i].packet = random_word();
                end
            end
        end
        dp_packet        <= dp_next;
        edge_packets     <= edge_next;
        pop              <= s.pop;
        cntl_done        <= s.done;
        replay_iter_flag <= s.replay;
    endtask

    task report_test;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed, %0d packet checks", cur_test, test_checks);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d errors in %0d packet checks",
                     cur_test, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            if (fifo_out.valid !== (m_fifo.size() != 0)) begin
                $display("At %0t fifo_out.valid is %b while the model holds %0d queued packets",
                         $time, fifo_out.valid, m_fifo.size());
                test_errors++;
                total_errors++;
            end else if (pop && m_fifo.size() != 0) begin
                check_value("fifo_out.packet", fifo_out.packet, m_fifo[0]);
            end
        end
    end

    initial begin
        reset            = 1'b1;
        dp_packet        = '0;
        edge_packets     = '0;
        cntl_done        = 1'b0;
        replay_iter_flag = 1'b0;
        pop              = 1'b0;
        checking         = 1'b0;
        table_ready      = 1'b0;
        lfsr_state       = LFSR_SEED;
        m_state          = M_IDLE;
        test_checks      = 0;
        test_errors      = 0;
        total_checks     = 0;
        total_errors     = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        build_table();
        cur_test    = steps[0].test;
        table_ready = 1'b1;

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            model_step();
        end
        reset <= 1'b0;
        checking = 1'b1;

        for (int k = 0; k < steps.size(); k++) begin
            @(posedge clk);
            model_step();
            if (steps[k].test != cur_test) begin
                report_test();
                cur_test = steps[k].test;
            end
            apply_step(steps[k]);
        end

        // Last row takes effect, then one more check cycle
        @(posedge clk);
        model_step();
        apply_step('0);
        @(posedge clk);
        checking = 1'b0;
        report_test();
        $display("%0d tests passed, %0d tests failed, %0d packet checks, %0d errors",
                 tests_passed, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog scaled to the table length
    initial begin
        wait (table_ready === 1'b1);
        #(steps.size() * CLK_PERIOD * 4);
        $display("Timeout: the run did not finish within %0d ns",
                 steps.size() * CLK_PERIOD * 4);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
